// ==== icache_pkg.sv ====
//////////////////////////////////////////////////
// L1 instruction cache shared definitions
// Widths, fetch operation and the packed structs
// passed between the pipeline stages and the
// memory engine
//////////////////////////////////////////////////

package icache_pkg;

  // Address and data widths
  localparam int addr_width        = 32;
  localparam int instr_width       = 32;
  localparam int block_width       = 128;
  localparam int words_per_block   = block_width / instr_width;
  localparam int word_offset_width = 2;
  localparam int byte_offset_width = 2;

  typedef enum logic
  {
    e_fetch = 1'b0,
    e_flush = 1'b1
  } fetch_op_e;

  // Request offered at the decode stage
  typedef struct packed
  {
    fetch_op_e              op;
    logic [addr_width-1:0]  addr;
  } fetch_req_t;

  typedef struct packed
  {
    logic [addr_width-1:0]  addr;
    logic [instr_width-1:0] instr;
  } fetch_resp_t;

  // One pipeline stage entry
  typedef struct packed
  {
    logic                   v;
    fetch_op_e              op;
    logic [addr_width-1:0]  addr;
  } stage_t;

  // Block-aligned miss address
  typedef struct packed
  {
    logic [addr_width-1:0]  addr;
  } fill_req_t;

  typedef struct packed
  {
    logic [block_width-1:0] data;
  } fill_resp_t;

endpackage

// ==== icache_way.sv ====
//////////////////////////////////////////////////
// Instruction cache way
// Tag, valid and data storage for one way with a
// synchronous read port, tag compare against the
// lookup address and a block refill write port
//////////////////////////////////////////////////

`timescale 1ns/1ns

module icache_way
  #(parameter int sets_p = 16)
  (
    input  logic                                 clk_i,
    input  logic                                 reset_i,
    input  logic                                 rd_en_i,
    input  logic [$clog2(sets_p)-1:0]            rd_index_i,
    input  logic [icache_pkg::addr_width-1:0]    cmp_addr_i,
    input  logic                                 flush_i,
    input  logic                                 wr_en_i,
    input  logic [icache_pkg::addr_width-1:0]    wr_addr_i,
    input  icache_pkg::fill_resp_t               wr_data_i,
    output logic                                 hit_o,
    output logic                                 valid_o,
    output logic [icache_pkg::block_width-1:0]   data_o
  );

  localparam int index_width_lp = $clog2(sets_p);
  localparam int block_off_lp   = icache_pkg::word_offset_width
                                + icache_pkg::byte_offset_width;
  localparam int tag_width_lp   = icache_pkg::addr_width - index_width_lp - block_off_lp;

  logic [tag_width_lp-1:0]            tag_mem [sets_p];
  logic [icache_pkg::block_width-1:0] data_mem [sets_p];
  logic [sets_p-1:0]                  valid_r;
  logic [tag_width_lp-1:0]            tag_rd_r;
  logic                               valid_rd_r;

  wire [index_width_lp-1:0] wr_index = wr_addr_i[block_off_lp +: index_width_lp];
  wire [tag_width_lp-1:0]   wr_tag   = wr_addr_i[icache_pkg::addr_width-1 -: tag_width_lp];
  wire [tag_width_lp-1:0]   cmp_tag  = cmp_addr_i[icache_pkg::addr_width-1 -: tag_width_lp];

  // Arrays keep the last read result until the next read
  always_ff @(posedge clk_i)
  begin
    if (wr_en_i)
    begin
      tag_mem[wr_index]  <= wr_tag;
      data_mem[wr_index] <= wr_data_i.data;
    end
    if (rd_en_i)
    begin
      tag_rd_r <= tag_mem[rd_index_i];
      data_o   <= data_mem[rd_index_i];
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i || flush_i)
      valid_r <= '0;
    else if (wr_en_i)
      valid_r[wr_index] <= 1'b1;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      valid_rd_r <= 1'b0;
    else if (rd_en_i)
      valid_rd_r <= valid_r[rd_index_i];
  end

  assign valid_o = valid_rd_r;
  assign hit_o   = valid_rd_r && (tag_rd_r == cmp_tag);

endmodule

// ==== icache_lookup.sv ====
//////////////////////////////////////////////////
// Instruction cache decode and tag lookup stage
// Accepts fetches against response credits, holds
// the lookup entry and drives way reads and flush
//////////////////////////////////////////////////

`timescale 1ns/1ns

module icache_lookup
  #(parameter int sets_p         = 16,
    parameter int resp_credits_p = 4)
  (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        fetch_v_i,
    input  icache_pkg::fetch_req_t      fetch_req_i,
    input  logic                        resp_credit_i,
    input  logic                        tv_busy_i,
    input  logic                        stall_i,
    input  logic                        recover_i,
    output logic                        fetch_ready_o,
    output icache_pkg::stage_t          tl_o,
    output logic                        rd_en_o,
    output logic [$clog2(sets_p)-1:0]   rd_index_o,
    output logic                        flush_o
  );

  localparam int index_width_lp  = $clog2(sets_p);
  localparam int block_off_lp    = icache_pkg::word_offset_width
                                 + icache_pkg::byte_offset_width;
  localparam int credit_width_lp = $clog2(resp_credits_p + 1);

  logic [credit_width_lp-1:0] credits_r;
  icache_pkg::stage_t         tl_r;
  logic                       accept;
  logic                       is_flush;

  //////////////////////////////////////////////////
  // Acceptance
  //////////////////////////////////////////////////
  assign is_flush = (fetch_req_i.op == icache_pkg::e_flush);

  // A flush waits until both stages have drained
  assign fetch_ready_o = !stall_i && (credits_r != '0)
                       && !(is_flush && (tl_r.v || tv_busy_i));
  assign accept        = fetch_v_i && fetch_ready_o;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      credits_r <= credit_width_lp'(resp_credits_p);
    else
      credits_r <= credits_r + credit_width_lp'(resp_credit_i)
                 - credit_width_lp'(accept && !is_flush);
  end

  //////////////////////////////////////////////////
  // Lookup stage register
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      tl_r.v <= 1'b0;
    else if (!stall_i)
      tl_r.v <= accept;
  end

  always_ff @(posedge clk_i)
  begin
    if (!stall_i && accept)
    begin
      tl_r.op   <= fetch_req_i.op;
      tl_r.addr <= fetch_req_i.addr;
    end
  end

  assign tl_o = tl_r;

  // Recover re-reads the set of the held entry
  assign rd_en_o    = (accept && !is_flush) || recover_i;
  assign rd_index_o = recover_i ? tl_r.addr[block_off_lp +: index_width_lp]
                                : fetch_req_i.addr[block_off_lp +: index_width_lp];
  assign flush_o    = accept && is_flush;

endmodule

// ==== icache_select.sv ====
//////////////////////////////////////////////////
// Instruction cache tag verify stage
// Registers the lookup entry with way results,
// selects hit way and word, holds a missed entry
// and answers it from the refilled block
//////////////////////////////////////////////////

`timescale 1ns/1ns

module icache_select
  #(parameter int ways_p = 4)
  (
    input  logic                                             clk_i,
    input  logic                                             reset_i,
    input  icache_pkg::stage_t                               tl_i,
    input  logic [ways_p-1:0]                                hit_i,
    input  logic [ways_p-1:0]                                way_valid_i,
    input  logic [ways_p-1:0][icache_pkg::block_width-1:0]   way_data_i,
    input  logic                                             fill_done_i,
    input  icache_pkg::fill_resp_t                           fill_block_i,
    output logic                                             resp_v_o,
    output icache_pkg::fetch_resp_t                          resp_o,
    output logic                                             tv_busy_o,
    output logic                                             miss_o,
    output icache_pkg::fill_req_t                            miss_req_o,
    output logic [ways_p-1:0]                                tv_valid_o,
    output logic                                             hit_v_o,
    output logic [$clog2(ways_p)-1:0]                        hit_way_o
  );

  localparam int block_off_lp = icache_pkg::word_offset_width
                              + icache_pkg::byte_offset_width;

  icache_pkg::stage_t                               tv_r;
  logic [ways_p-1:0]                                hit_r;
  logic [ways_p-1:0]                                valid_r;
  logic [ways_p-1:0][icache_pkg::block_width-1:0]   data_r;
  logic [icache_pkg::block_width-1:0]               hit_block;
  logic [icache_pkg::block_width-1:0]               resp_block;
  logic [icache_pkg::word_offset_width-1:0]         word_sel;
  logic                                             hold;
  logic                                             is_fetch;

  //////////////////////////////////////////////////
  // Verify stage register
  //////////////////////////////////////////////////
  // Missed entry stays until the refill answers it
  assign hold = miss_o || fill_done_i;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      tv_r.v <= 1'b0;
    else if (fill_done_i)
      tv_r.v <= 1'b0;
    else if (!hold)
      tv_r.v <= tl_i.v;
  end

  always_ff @(posedge clk_i)
  begin
    if (!hold)
    begin
      tv_r.op   <= tl_i.op;
      tv_r.addr <= tl_i.addr;
      hit_r     <= hit_i;
      valid_r   <= way_valid_i;
      data_r    <= way_data_i;
    end
  end

  //////////////////////////////////////////////////
  // Hit way and word selection
  //////////////////////////////////////////////////
  always_comb
  begin
    hit_block = '0;
    hit_way_o = '0;
    for (int w = 0; w < ways_p; w++)
    begin
      if (hit_r[w])
      begin
        hit_block = hit_block | data_r[w];
        hit_way_o = $clog2(ways_p)'(w);
      end
    end
  end

  assign is_fetch   = tv_r.v && (tv_r.op == icache_pkg::e_fetch);
  assign miss_o     = is_fetch && !(|hit_r) && !fill_done_i;
  assign hit_v_o    = is_fetch && (|hit_r);
  assign tv_busy_o  = tv_r.v;
  assign tv_valid_o = valid_r;

  // Block address of the entry, used for fills and tree updates
  assign miss_req_o.addr = {tv_r.addr[icache_pkg::addr_width-1:block_off_lp],
                            {block_off_lp{1'b0}}};

  assign word_sel   = tv_r.addr[icache_pkg::byte_offset_width +: icache_pkg::word_offset_width];
  assign resp_block = fill_done_i ? fill_block_i.data : hit_block;

  assign resp_v_o       = is_fetch && ((|hit_r) || fill_done_i);
  assign resp_o.addr    = tv_r.addr;
  assign resp_o.instr   = resp_block[word_sel*icache_pkg::instr_width +: icache_pkg::instr_width];

endmodule

// ==== icache_refill.sv ====
//////////////////////////////////////////////////
// Instruction cache refill control
// Miss FSM with fill request and response, victim
// choice and per-set pseudo-LRU tree state
//////////////////////////////////////////////////

`timescale 1ns/1ns

module icache_refill
  #(parameter int sets_p = 16,
    parameter int ways_p = 4)
  (
    input  logic                                clk_i,
    input  logic                                reset_i,
    input  logic                                miss_i,
    input  icache_pkg::fill_req_t               miss_req_i,
    input  logic [ways_p-1:0]                   tv_valid_i,
    input  logic                                hit_v_i,
    input  logic [$clog2(ways_p)-1:0]           hit_way_i,
    input  logic                                fill_req_yumi_i,
    input  logic                                fill_resp_v_i,
    input  icache_pkg::fill_resp_t              fill_resp_i,
    output logic                                fill_req_v_o,
    output icache_pkg::fill_req_t               fill_req_o,
    output logic [ways_p-1:0]                   wr_en_o,
    output logic [icache_pkg::addr_width-1:0]   wr_addr_o,
    output icache_pkg::fill_resp_t              wr_data_o,
    output logic                                fill_done_o,
    output icache_pkg::fill_resp_t              fill_block_o,
    output logic                                stall_o,
    output logic                                recover_o
  );

  localparam int index_width_lp = $clog2(sets_p);
  localparam int lg_ways_lp     = $clog2(ways_p);
  localparam int block_off_lp   = icache_pkg::word_offset_width
                                + icache_pkg::byte_offset_width;

  typedef enum logic [1:0] {e_ready, e_request, e_wait, e_recover} state_e;

  state_e                         state_r;
  icache_pkg::fill_req_t          req_r;
  icache_pkg::fill_resp_t         block_r;
  logic [lg_ways_lp-1:0]          victim_r;
  logic [sets_p-1:0][ways_p-2:0]  plru_r;

  logic [lg_ways_lp-1:0]          inv_way;
  logic                           inv_found;
  logic [lg_ways_lp-1:0]          lru_way;
  logic [lg_ways_lp-1:0]          upd_way;
  logic [index_width_lp-1:0]      upd_index;
  logic [ways_p-2:0]              upd_bits;
  logic                           fill_write;
  int                             node;
  int                             unode;

  wire [index_width_lp-1:0] tv_index  = miss_req_i.addr[block_off_lp +: index_width_lp];
  wire [index_width_lp-1:0] req_index = req_r.addr[block_off_lp +: index_width_lp];

  //////////////////////////////////////////////////
  // Miss FSM
  //////////////////////////////////////////////////
  assign fill_write = (state_r == e_wait) && fill_resp_v_i;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= e_ready;
    else
    begin
      case (state_r)
        e_ready:   if (miss_i) state_r <= e_request;
        e_request: if (fill_req_yumi_i) state_r <= e_wait;
        e_wait:    if (fill_resp_v_i) state_r <= e_recover;
        default:   state_r <= e_ready;
      endcase
    end
  end

  // Miss address and victim are captured when the miss is seen
  always_ff @(posedge clk_i)
  begin
    if ((state_r == e_ready) && miss_i)
    begin
      req_r    <= miss_req_i;
      victim_r <= inv_found ? inv_way : lru_way;
    end
    if (fill_write)
      block_r <= fill_resp_i;
  end

  assign fill_req_v_o = (state_r == e_request);
  assign fill_req_o   = req_r;
  assign wr_en_o      = fill_write ? (ways_p'(1) << victim_r) : '0;
  assign wr_addr_o    = req_r.addr;
  assign wr_data_o    = fill_resp_i;
  assign fill_done_o  = (state_r == e_recover);
  assign recover_o    = (state_r == e_recover);
  assign fill_block_o = block_r;
  assign stall_o      = miss_i || (state_r != e_ready);

  //////////////////////////////////////////////////
  // Replacement
  //////////////////////////////////////////////////
  // Lowest invalid way wins over the tree
  always_comb
  begin
    inv_found = 1'b0;
    inv_way   = '0;
    for (int w = ways_p - 1; w >= 0; w--)
    begin
      if (!tv_valid_i[w])
      begin
        inv_found = 1'b1;
        inv_way   = lg_ways_lp'(w);
      end
    end
  end

  // Walk the tree along the node bits
  always_comb
  begin
    node    = 0;
    lru_way = '0;
    for (int l = 0; l < lg_ways_lp; l++)
    begin
      lru_way[lg_ways_lp-1-l] = plru_r[tv_index][node];
      node = 2 * node + 1 + int'(plru_r[tv_index][node]);
    end
  end

  // Point each node on the used path away from the used way
  always_comb
  begin
    upd_way   = hit_v_i ? hit_way_i : victim_r;
    upd_index = hit_v_i ? tv_index : req_index;
    upd_bits  = plru_r[upd_index];
    unode     = 0;
    for (int l = 0; l < lg_ways_lp; l++)
    begin
      upd_bits[unode] = !upd_way[lg_ways_lp-1-l];
      unode = 2 * unode + 1 + int'(upd_way[lg_ways_lp-1-l]);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      plru_r <= '0;
    else if (hit_v_i || fill_write)
      plru_r[upd_index] <= upd_bits;
  end

endmodule

// ==== icache_top.sv ====
//////////////////////////////////////////////////
// L1 instruction cache top level
// Lookup stage, way array, verify stage and refill
// control of a set-associative fetch cache
//////////////////////////////////////////////////

`timescale 1ns/1ns

module icache_top
  #(parameter int sets_p         = 16,
    parameter int ways_p         = 4,
    parameter int resp_credits_p = 4)
  (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        fetch_v_i,
    input  icache_pkg::fetch_req_t      fetch_req_i,
    output logic                        fetch_ready_o,
    output logic                        resp_v_o,
    output icache_pkg::fetch_resp_t     resp_o,
    input  logic                        resp_credit_i,
    output logic                        fill_req_v_o,
    output icache_pkg::fill_req_t       fill_req_o,
    input  logic                        fill_req_yumi_i,
    input  logic                        fill_resp_v_i,
    input  icache_pkg::fill_resp_t      fill_resp_i
  );

  icache_pkg::stage_t                               tl;
  logic                                             rd_en;
  logic [$clog2(sets_p)-1:0]                        rd_index;
  logic                                             flush;
  logic [ways_p-1:0]                                hit;
  logic [ways_p-1:0]                                way_valid;
  logic [ways_p-1:0][icache_pkg::block_width-1:0]   way_data;
  logic [ways_p-1:0]                                wr_en;
  logic [icache_pkg::addr_width-1:0]                wr_addr;
  icache_pkg::fill_resp_t                           wr_data;
  icache_pkg::fill_resp_t                           fill_block;
  icache_pkg::fill_req_t                            miss_req;
  logic [ways_p-1:0]                                tv_valid;
  logic [$clog2(ways_p)-1:0]                        hit_way;
  logic                                             tv_busy;
  logic                                             miss;
  logic                                             hit_v;
  logic                                             fill_done;
  logic                                             stall;
  logic                                             recover;

  icache_lookup #(.sets_p(sets_p), .resp_credits_p(resp_credits_p)) lookup_i
  (
    .clk_i(clk_i), .reset_i(reset_i),
    .fetch_v_i(fetch_v_i), .fetch_req_i(fetch_req_i), .resp_credit_i(resp_credit_i),
    .tv_busy_i(tv_busy), .stall_i(stall), .recover_i(recover),
    .fetch_ready_o(fetch_ready_o), .tl_o(tl),
    .rd_en_o(rd_en), .rd_index_o(rd_index), .flush_o(flush)
  );

  for (genvar w = 0; w < ways_p; w++)
  begin : way
    icache_way #(.sets_p(sets_p)) way_i
    (
      .clk_i(clk_i), .reset_i(reset_i),
      .rd_en_i(rd_en), .rd_index_i(rd_index), .cmp_addr_i(tl.addr), .flush_i(flush),
      .wr_en_i(wr_en[w]), .wr_addr_i(wr_addr), .wr_data_i(wr_data),
      .hit_o(hit[w]), .valid_o(way_valid[w]), .data_o(way_data[w])
    );
  end

  icache_select #(.ways_p(ways_p)) select_i
  (
    .clk_i(clk_i), .reset_i(reset_i),
    .tl_i(tl), .hit_i(hit), .way_valid_i(way_valid), .way_data_i(way_data),
    .fill_done_i(fill_done), .fill_block_i(fill_block),
    .resp_v_o(resp_v_o), .resp_o(resp_o), .tv_busy_o(tv_busy),
    .miss_o(miss), .miss_req_o(miss_req), .tv_valid_o(tv_valid),
    .hit_v_o(hit_v), .hit_way_o(hit_way)
  );

  icache_refill #(.sets_p(sets_p), .ways_p(ways_p)) refill_i
  (
    .clk_i(clk_i), .reset_i(reset_i),
    .miss_i(miss), .miss_req_i(miss_req), .tv_valid_i(tv_valid),
    .hit_v_i(hit_v), .hit_way_i(hit_way),
    .fill_req_yumi_i(fill_req_yumi_i), .fill_resp_v_i(fill_resp_v_i),
    .fill_resp_i(fill_resp_i),
    .fill_req_v_o(fill_req_v_o), .fill_req_o(fill_req_o),
    .wr_en_o(wr_en), .wr_addr_o(wr_addr), .wr_data_o(wr_data),
    .fill_done_o(fill_done), .fill_block_o(fill_block),
    .stall_o(stall), .recover_o(recover)
  );

endmodule

// ==== tb_icache.sv ====
//////////////////////////////////////////////////
// Instruction cache testbench
// Random fetch traffic checked against a cache
// reference model, with a memory engine model,
// credit checks and engine back-pressure
//////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_icache;

  localparam int resp_credits   = 4;
  localparam int small_delay    = 4;
  localparam int large_delay    = 28;
  localparam int random_reqs    = 200;
  localparam int stress_reqs    = 120;
  localparam int total_reqs     = random_reqs + stress_reqs + 40;
  localparam int hold_cycles    = 100;
  localparam int timeout_cycles = total_reqs * (2 * large_delay + 12) + hold_cycles + 1000;

  typedef struct packed
  {
    logic [31:0] addr;
    logic [31:0] instr;
    logic [31:0] cyc;
  } expect_t;

  logic                    clk_i;
  logic                    reset_i;
  logic                    fetch_v_i;
  icache_pkg::fetch_req_t  fetch_req_i;
  logic                    fetch_ready_o;
  logic                    resp_v_o;
  icache_pkg::fetch_resp_t resp_o;
  logic                    resp_credit_i;
  logic                    fill_req_v_o;
  icache_pkg::fill_req_t   fill_req_o;
  logic                    fill_req_yumi_i;
  logic                    fill_resp_v_i;
  icache_pkg::fill_resp_t  fill_resp_i;

  // Reference model of 16 sets by 4 ways
  logic [27:0] m_blk [16][4];
  logic        m_valid [16][4];
  logic [2:0]  m_plru [16];

  icache_pkg::fetch_req_t pending_q[$];
  expect_t                exp_q[$];
  logic [31:0]            exp_fill_q[$];

  logic [31:0] rng;
  logic [31:0] held_fill_addr;
  logic [31:0] last_fill;
  logic [31:0] fill_addr;
  int          cyc;
  int          errors;
  int          test_err_start;
  int          tests_run;
  int          tests_failed;
  int          credits;
  int          credit_owed;
  int          accepted;
  int          fills_seen;
  int          fills_before;
  int          yumi_count;
  int          resp_count;
  int          yumi_max;
  int          resp_max;
  int          timeout_count;
  bit          req_waiting;
  bit          resp_pending;
  bit          timing_on;
  bit          gaps_on;
  bit          credit_hold;

  icache_top dut_i
  (
    .clk_i(clk_i), .reset_i(reset_i),
    .fetch_v_i(fetch_v_i), .fetch_req_i(fetch_req_i), .fetch_ready_o(fetch_ready_o),
    .resp_v_o(resp_v_o), .resp_o(resp_o), .resp_credit_i(resp_credit_i),
    .fill_req_v_o(fill_req_v_o), .fill_req_o(fill_req_o), .fill_req_yumi_i(fill_req_yumi_i),
    .fill_resp_v_i(fill_resp_v_i), .fill_resp_i(fill_resp_i)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Random numbers and memory contents
  //////////////////////////////////////////////////
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  // Instruction word stored at a word address
  function automatic logic [31:0] mem_word(input logic [31:0] word_addr);
    return (word_addr * 32'h9e3779b1) ^ {word_addr[15:0], word_addr[31:16]} ^ 32'h0f0f1234;
  endfunction

  function automatic icache_pkg::fill_resp_t make_block(input logic [31:0] block_addr);
    icache_pkg::fill_resp_t b;
    for (int i = 0; i < 4; i++)
      b.data[32*i +: 32] = mem_word((block_addr >> 2) + 32'(i));
    return b;
  endfunction

  // Six blocks compete for four ways in each of four sets
  function automatic logic [31:0] rand_addr();
    logic [31:0] r;
    r = next_rand();
    return 32'h0001_0000 + ((r % 6) << 8) + (((r >> 8) % 4) << 4) + (((r >> 16) % 4) << 2);
  endfunction

  task automatic push_req(input icache_pkg::fetch_op_e op, input logic [31:0] addr);
    icache_pkg::fetch_req_t req;
    req.op   = op;
    req.addr = addr;
    pending_q.push_back(req);
  endtask

  task automatic push_random(input int count, input bit with_flush);
    for (int i = 0; i < count; i++)
    begin
      if (with_flush && (next_rand() % 40 == 0))
        push_req(icache_pkg::e_flush, rand_addr());
      else
        push_req(icache_pkg::e_fetch, rand_addr());
    end
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////
  // Root bit picks a pair of ways, leaf bit picks a way in it
  function automatic int plru_victim(input int set);
    if (m_plru[set][0] == 1'b0)
      return int'(m_plru[set][1]);
    else
      return 2 + int'(m_plru[set][2]);
  endfunction

  task automatic plru_touch(input int set, input int way);
    m_plru[set][0] = (way < 2);
    if (way < 2)
      m_plru[set][1] = (way == 0);
    else
      m_plru[set][2] = (way == 2);
  endtask

  task automatic model_accept(input icache_pkg::fetch_req_t req);
    int      set;
    int      way;
    expect_t e;
    set = int'(req.addr[7:4]);
    way = -1;
    if (req.op == icache_pkg::e_flush)
    begin
      for (int s = 0; s < 16; s++)
        for (int w = 0; w < 4; w++)
          m_valid[s][w] = 1'b0;
    end
    else
    begin
      for (int w = 0; w < 4; w++)
        if (m_valid[set][w] && (m_blk[set][w] == req.addr[31:4]))
          way = w;
      if (way < 0)
      begin
        way = plru_victim(set);
        // Lowest invalid way first
        for (int w = 3; w >= 0; w--)
          if (!m_valid[set][w])
            way = w;
        exp_fill_q.push_back({req.addr[31:4], 4'h0});
        m_blk[set][way]   = req.addr[31:4];
        m_valid[set][way] = 1'b1;
      end
      plru_touch(set, way);
      e.addr  = req.addr;
      e.instr = mem_word(req.addr >> 2);
      e.cyc   = cyc;
      exp_q.push_back(e);
    end
  endtask

  //////////////////////////////////////////////////
  // Checks, observation and driving
  //////////////////////////////////////////////////
  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("[ERROR] %s: got %h, expected %h at cycle %0d", name, got, exp, cyc);
      errors++;
    end
  endtask

  task automatic report(input string what);
    $display("error: %s at cycle %0d", what, cyc);
    errors++;
  endtask

  // Sampled at the falling edge, for the transfers of the next rising edge
  task automatic observe();
    expect_t e;
    cyc++;
    if (req_waiting)
    begin
      check("fill_req_v_o", 32'(fill_req_v_o), 32'd1);
      check("fill_req_o", fill_req_o.addr, held_fill_addr);
    end
    else if (fill_req_v_o && !fill_req_yumi_i)
      yumi_count = int'(next_rand() % (yumi_max + 1));
    req_waiting    = fill_req_v_o && !fill_req_yumi_i;
    held_fill_addr = fill_req_o.addr;
    if (fill_req_v_o && fill_req_yumi_i)
    begin
      if (exp_fill_q.size() == 0)
        report("fill request with no miss expected");
      else
        check("fill_req_o", fill_req_o.addr, exp_fill_q.pop_front());
      fills_seen++;
      last_fill    = fill_req_o.addr;
      fill_addr    = fill_req_o.addr;
      resp_pending = 1'b1;
      resp_count   = int'(next_rand() % (resp_max + 1));
    end
    if (resp_v_o)
    begin
      if (exp_q.size() == 0)
        report("response with no fetch outstanding");
      else
      begin
        e = exp_q.pop_front();
        check("resp_o.addr", resp_o.addr, e.addr);
        check("resp_o.instr", resp_o.instr, e.instr);
        if (timing_on)
          check("resp_latency", 32'(cyc) - e.cyc, 32'd2);
      end
      credit_owed++;
    end
    if (fetch_v_i && fetch_ready_o)
    begin
      if (pending_q[0].op == icache_pkg::e_fetch)
      begin
        check("credit_available", 32'(credits > 0), 32'd1);
        credits--;
        accepted++;
      end
      model_accept(pending_q.pop_front());
    end
    if (resp_credit_i)
      credits++;
  endtask

  task automatic drive();
    fetch_v_i <= (pending_q.size() > 0) && (!gaps_on || (next_rand() % 4 != 0));
    if (pending_q.size() > 0)
      fetch_req_i <= pending_q[0];
    // Engine takes the request after a random delay
    fill_req_yumi_i <= 1'b0;
    if (req_waiting)
    begin
      if (yumi_count == 0)
        fill_req_yumi_i <= 1'b1;
      else
        yumi_count--;
    end
    fill_resp_v_i <= 1'b0;
    if (resp_pending)
    begin
      if (resp_count == 0)
      begin
        fill_resp_v_i <= 1'b1;
        fill_resp_i   <= make_block(fill_addr);
        resp_pending  = 1'b0;
      end
      else
        resp_count--;
    end
    resp_credit_i <= 1'b0;
    if (!credit_hold && (credit_owed > 0) && (next_rand() % 2 == 1))
    begin
      resp_credit_i <= 1'b1;
      credit_owed--;
    end
  endtask

  task automatic run_cycle();
    @(negedge clk_i);
    observe();
    @(posedge clk_i);
    drive();
  endtask

  task automatic drain();
    while ((pending_q.size() > 0) || (exp_q.size() > 0) || resp_pending
           || ((credit_owed > 0) && !credit_hold))
      run_cycle();
    repeat (4) run_cycle();
  endtask

  task automatic end_test(input string name);
    tests_run++;
    check("unanswered_fills", 32'(exp_fill_q.size()), 32'd0);
    if (errors == test_err_start)
      $display("%s: ok", name);
    else
    begin
      $display("%s: FAIL with %0d errors", name, errors - test_err_start);
      tests_failed++;
    end
    test_err_start = errors;
  endtask

  initial
  begin
    timeout_count = 0;
    while (timeout_count < timeout_cycles)
    begin
      @(posedge clk_i);
      timeout_count++;
    end
    $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
    $display("test failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  initial
  begin
    rng             = 32'h3777b10b;
    cyc             = 0;
    errors          = 0;
    test_err_start  = 0;
    tests_run       = 0;
    tests_failed    = 0;
    credits         = resp_credits;
    credit_owed     = 0;
    accepted        = 0;
    fills_seen      = 0;
    fills_before    = 0;
    yumi_count      = 0;
    resp_count      = 0;
    yumi_max        = small_delay;
    resp_max        = small_delay;
    req_waiting     = 1'b0;
    resp_pending    = 1'b0;
    timing_on       = 1'b0;
    gaps_on         = 1'b0;
    credit_hold     = 1'b0;
    held_fill_addr  = '0;
    last_fill       = '0;
    fill_addr       = '0;
    reset_i         = 1'b1;
    fetch_v_i       = 1'b0;
    fetch_req_i     = '0;
    resp_credit_i   = 1'b0;
    fill_req_yumi_i = 1'b0;
    fill_resp_v_i   = 1'b0;
    fill_resp_i     = '0;
    for (int s = 0; s < 16; s++)
    begin
      m_plru[s] = '0;
      for (int w = 0; w < 4; w++)
      begin
        m_blk[s][w]   = '0;
        m_valid[s][w] = 1'b0;
      end
    end
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;

    @(negedge clk_i);
    check("resp_v_o", 32'(resp_v_o), 32'd0);
    check("fill_req_v_o", 32'(fill_req_v_o), 32'd0);
    check("fetch_ready_o", 32'(fetch_ready_o), 32'd1);
    end_test("reset");

    // Bring one block in, then hit it back to back
    push_req(icache_pkg::e_fetch, 32'h0002_0040);
    drain();
    timing_on = 1'b1;
    for (int i = 0; i < 8; i++)
      push_req(icache_pkg::e_fetch, 32'h0002_0040 + 32'(4 * (i % 4)));
    drain();
    timing_on = 1'b0;
    end_test("hit data and timing");

    gaps_on = 1'b1;
    push_random(random_reqs, 1'b1);
    drain();
    end_test("miss handling and ordering");

    gaps_on = 1'b0;
    check("credits", 32'(credits), 32'(resp_credits));
    credit_hold = 1'b1;
    accepted    = 0;
    push_random(10, 1'b0);
    repeat (hold_cycles) run_cycle();
    check("accepted_without_credits", 32'(accepted), 32'(resp_credits));
    credit_hold = 1'b0;
    drain();
    check("accepted_after_credits", 32'(accepted), 32'd10);
    end_test("credits");

    push_req(icache_pkg::e_fetch, 32'h0003_0080);
    drain();
    fills_before = fills_seen;
    push_req(icache_pkg::e_flush, 32'h0000_0000);
    push_req(icache_pkg::e_fetch, 32'h0003_0084);
    drain();
    check("fills_after_flush", 32'(fills_seen - fills_before), 32'd1);
    check("fill_req_o", last_fill, 32'h0003_0080);
    end_test("flush");

    gaps_on  = 1'b1;
    yumi_max = large_delay;
    resp_max = large_delay;
    push_random(stress_reqs, 1'b1);
    drain();
    end_test("engine back-pressure");

    $display("summary: %0d tests, %0d with errors, %0d errors in total",
             tests_run, tests_failed, errors);
    if (errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

// ==== verilog.f ====
icache_pkg.sv
icache_way.sv
icache_lookup.sv
icache_select.sv
icache_refill.sv
icache_top.sv
tb_icache.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing -j 0
TOP       := tb_icache
FILELIST  := verilog.f
SIM       := sim_$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

# Pass or fail comes from the pass message in the simulation output
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(SIM)
	@out="$$(./obj_dir/$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
